//--- dist_net.f
rtl/dn_pkg.sv
rtl/mux_2x1_simple_comb.sv
rtl/distribute_1x2_simple_comb.sv
rtl/dn_tree_1x4.sv
rtl/dn_cfg_axil.sv
rtl/dn_top.sv
sim/dn_tb.sv

//--- rtl/distribute_1x2_simple_comb.sv
module distribute_1x2_simple_comb #(
	parameter int DATA_WIDTH = 32
)(
	// incoming word
	input  logic                    i_valid,
	input  logic [DATA_WIDTH-1:0]   i_data_bus,
	// control
	input  logic                    i_en,
	input  dn_pkg::dist_cmd_e       i_cmd,
	// branch outputs, bit/word 1 is branch high
	output logic [1:0]              o_valid,
	output logic [2*DATA_WIDTH-1:0] o_data_bus
);

	////////////////////
	// mux inputs

	// pair 0 is the zero dummy, pair 1 the live word
	logic [1:0]              mux_valid;
	logic [2*DATA_WIDTH-1:0] mux_data;

	assign mux_valid = {i_valid, 1'b0};
	assign mux_data  = {i_data_bus, {DATA_WIDTH{1'b0}}};

	////////////////////
	// one mux per branch

	// branch low follows cmd bit 0
	mux_2x1_simple_comb #(
		.DATA_WIDTH (DATA_WIDTH)
	) u_mux_low (
		.i_valid    (mux_valid),
		.i_data_bus (mux_data),
		.i_en       (i_en),
		.i_cmd      (i_cmd[0]),
		.o_valid    (o_valid[0]),
		.o_data_bus (o_data_bus[0 +: DATA_WIDTH])
	);

	// branch high follows cmd bit 1
	// both bits set duplicates the word
	mux_2x1_simple_comb #(
		.DATA_WIDTH (DATA_WIDTH)
	) u_mux_high (
		.i_valid    (mux_valid),
		.i_data_bus (mux_data),
		.i_en       (i_en),
		.i_cmd      (i_cmd[1]),
		.o_valid    (o_valid[1]),
		.o_data_bus (o_data_bus[DATA_WIDTH +: DATA_WIDTH])
	);

endmodule

//--- rtl/dn_cfg_axil.sv
module dn_cfg_axil (
	input  logic                                   clk,
	input  logic                                   i_reset,
	// write address
	input  logic                                   i_s_axil_awvalid,
	input  logic [dn_pkg::AXIL_ADDR_WIDTH-1:0]     i_s_axil_awaddr,
	output logic                                   o_s_axil_awready,
	// write data
	input  logic                                   i_s_axil_wvalid,
	input  logic [dn_pkg::AXIL_DATA_WIDTH-1:0]     i_s_axil_wdata,
	input  logic [dn_pkg::AXIL_DATA_WIDTH/8-1:0]   i_s_axil_wstrb,
	output logic                                   o_s_axil_wready,
	// write response
	output logic                                   o_s_axil_bvalid,
	output dn_pkg::axil_resp_e                     o_s_axil_bresp,
	input  logic                                   i_s_axil_bready,
	// read address
	input  logic                                   i_s_axil_arvalid,
	input  logic [dn_pkg::AXIL_ADDR_WIDTH-1:0]     i_s_axil_araddr,
	output logic                                   o_s_axil_arready,
	// read data
	output logic                                   o_s_axil_rvalid,
	output logic [dn_pkg::AXIL_DATA_WIDTH-1:0]     o_s_axil_rdata,
	output dn_pkg::axil_resp_e                     o_s_axil_rresp,
	input  logic                                   i_s_axil_rready,
	// tree control
	output logic                                   o_en,
	output dn_pkg::dist_cmd_e                      o_cmd_root,
	output dn_pkg::dist_cmd_e                      o_cmd_low,
	output dn_pkg::dist_cmd_e                      o_cmd_high
);

	logic                               write_fire;
	logic                               read_fire;
	logic [dn_pkg::AXIL_DATA_WIDTH-1:0] ctrl_word;
	logic [dn_pkg::AXIL_DATA_WIDTH-1:0] cmd_word;
	logic [dn_pkg::AXIL_DATA_WIDTH-1:0] ctrl_next;
	logic [dn_pkg::AXIL_DATA_WIDTH-1:0] cmd_next;

	// byte-wise merge of write data into the current value
	function automatic logic [dn_pkg::AXIL_DATA_WIDTH-1:0] merge_strb(
		input logic [dn_pkg::AXIL_DATA_WIDTH-1:0]   old_word,
		input logic [dn_pkg::AXIL_DATA_WIDTH-1:0]   new_word,
		input logic [dn_pkg::AXIL_DATA_WIDTH/8-1:0] strb
	);
		logic [dn_pkg::AXIL_DATA_WIDTH-1:0] result;
		int                                 b;
		result = old_word;
		for (b = 0; b < dn_pkg::AXIL_DATA_WIDTH/8; b++)
		begin
			if (strb[b])
			begin
				result[8*b +: 8] = new_word[8*b +: 8];
			end
		end
		return result;
	endfunction

	////////////////////
	// register views

	always_comb
	begin
		// unused bits read as zero
		ctrl_word      = '0;
		ctrl_word[0]   = o_en;
		cmd_word       = '0;
		cmd_word[5:0]  = {o_cmd_high, o_cmd_low, o_cmd_root};
		ctrl_next      = merge_strb(ctrl_word, i_s_axil_wdata, i_s_axil_wstrb);
		cmd_next       = merge_strb(cmd_word, i_s_axil_wdata, i_s_axil_wstrb);
	end

	assign write_fire = o_s_axil_awready & i_s_axil_awvalid
		& o_s_axil_wready & i_s_axil_wvalid;
	assign read_fire  = o_s_axil_arready & i_s_axil_arvalid;

	////////////////////
	// write channel

	always_ff @(posedge clk)
	begin
		if (i_reset)
		begin
			o_s_axil_awready <= 1'b0;
			o_s_axil_wready  <= 1'b0;
			o_s_axil_bvalid  <= 1'b0;
			o_en             <= 1'b0;
			o_cmd_root       <= dn_pkg::CMD_NONE;
			o_cmd_low        <= dn_pkg::CMD_NONE;
			o_cmd_high       <= dn_pkg::CMD_NONE;
		end
		else
		begin
			// one-cycle ready pulse, needs address and data together
			// and no response still waiting
			o_s_axil_awready <= !o_s_axil_awready && !o_s_axil_bvalid
				&& i_s_axil_awvalid && i_s_axil_wvalid;
			o_s_axil_wready  <= !o_s_axil_awready && !o_s_axil_bvalid
				&& i_s_axil_awvalid && i_s_axil_wvalid;

			if (write_fire)
			begin
				o_s_axil_bvalid <= 1'b1;
				// unmapped address writes nothing
				if (i_s_axil_awaddr == dn_pkg::REG_CTRL_ADDR)
				begin
					o_en <= ctrl_next[0];
				end
				else if (i_s_axil_awaddr == dn_pkg::REG_CMD_ADDR)
				begin
					o_cmd_root <= dn_pkg::dist_cmd_e'(cmd_next[1:0]);
					o_cmd_low  <= dn_pkg::dist_cmd_e'(cmd_next[3:2]);
					o_cmd_high <= dn_pkg::dist_cmd_e'(cmd_next[5:4]);
				end
			end
			else if (o_s_axil_bvalid && i_s_axil_bready)
			begin
				o_s_axil_bvalid <= 1'b0;
			end
		end
	end

	// response code, held with bvalid
	always_ff @(posedge clk)
	begin
		if (write_fire)
		begin
			if (i_s_axil_awaddr == dn_pkg::REG_CTRL_ADDR
				|| i_s_axil_awaddr == dn_pkg::REG_CMD_ADDR)
			begin
				o_s_axil_bresp <= dn_pkg::RESP_OKAY;
			end
			else
			begin
				o_s_axil_bresp <= dn_pkg::RESP_SLVERR;
			end
		end
	end

	////////////////////
	// read channel

	always_ff @(posedge clk)
	begin
		if (i_reset)
		begin
			o_s_axil_arready <= 1'b0;
			o_s_axil_rvalid  <= 1'b0;
		end
		else
		begin
			// accept only with no read response pending
			o_s_axil_arready <= !o_s_axil_arready && !o_s_axil_rvalid
				&& i_s_axil_arvalid;
			if (read_fire)
			begin
				o_s_axil_rvalid <= 1'b1;
			end
			else if (o_s_axil_rvalid && i_s_axil_rready)
			begin
				o_s_axil_rvalid <= 1'b0;
			end
		end
	end

	// read payload
	always_ff @(posedge clk)
	begin
		if (read_fire)
		begin
			case (i_s_axil_araddr)
				dn_pkg::REG_CTRL_ADDR:
				begin
					o_s_axil_rdata <= ctrl_word;
					o_s_axil_rresp <= dn_pkg::RESP_OKAY;
				end
				dn_pkg::REG_CMD_ADDR:
				begin
					o_s_axil_rdata <= cmd_word;
					o_s_axil_rresp <= dn_pkg::RESP_OKAY;
				end
				default:
				begin
					// unmapped, zero data with error
					o_s_axil_rdata <= '0;
					o_s_axil_rresp <= dn_pkg::RESP_SLVERR;
				end
			endcase
		end
	end

endmodule

//--- rtl/dn_pkg.sv
package dn_pkg;

	////////////////////
	// data stream

	// one word on the stream
	localparam int DATA_WIDTH = 32;
	// leaves of the two-level tree
	localparam int NUM_LEAVES = 4;

	typedef logic [DATA_WIDTH-1:0] data_t;

	// switch command, bit 0 picks branch low, bit 1 picks branch high
	typedef enum logic [1:0] {
		CMD_NONE = 2'b00,
		CMD_LOW  = 2'b01,
		CMD_HIGH = 2'b10,
		CMD_DUP  = 2'b11
	} dist_cmd_e;

	////////////////////
	// configuration port

	localparam int AXIL_ADDR_WIDTH = 4;
	localparam int AXIL_DATA_WIDTH = 32;

	// only okay and slave error are ever returned
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axil_resp_e;

	// register map
	// ctrl: bit 0 enable
	localparam logic [AXIL_ADDR_WIDTH-1:0] REG_CTRL_ADDR = 4'h0;
	// cmd: [1:0] root, [3:2] low child, [5:4] high child
	localparam logic [AXIL_ADDR_WIDTH-1:0] REG_CMD_ADDR  = 4'h4;

endpackage

//--- rtl/dn_top.sv
module dn_top (
	input  logic                                     clk,
	input  logic                                     i_reset,
	// configuration port
	input  logic                                     i_s_axil_awvalid,
	input  logic [dn_pkg::AXIL_ADDR_WIDTH-1:0]       i_s_axil_awaddr,
	output logic                                     o_s_axil_awready,
	input  logic                                     i_s_axil_wvalid,
	input  logic [dn_pkg::AXIL_DATA_WIDTH-1:0]       i_s_axil_wdata,
	input  logic [dn_pkg::AXIL_DATA_WIDTH/8-1:0]     i_s_axil_wstrb,
	output logic                                     o_s_axil_wready,
	output logic                                     o_s_axil_bvalid,
	output dn_pkg::axil_resp_e                       o_s_axil_bresp,
	input  logic                                     i_s_axil_bready,
	input  logic                                     i_s_axil_arvalid,
	input  logic [dn_pkg::AXIL_ADDR_WIDTH-1:0]       i_s_axil_araddr,
	output logic                                     o_s_axil_arready,
	output logic                                     o_s_axil_rvalid,
	output logic [dn_pkg::AXIL_DATA_WIDTH-1:0]       o_s_axil_rdata,
	output dn_pkg::axil_resp_e                       o_s_axil_rresp,
	input  logic                                     i_s_axil_rready,
	// data stream, no back-pressure
	input  logic                                     i_valid,
	input  dn_pkg::data_t                            i_data,
	output logic [dn_pkg::NUM_LEAVES-1:0]            o_valid,
	output dn_pkg::data_t [dn_pkg::NUM_LEAVES-1:0]   o_data
);

	// register outputs into the tree
	logic              en;
	dn_pkg::dist_cmd_e cmd_root;
	dn_pkg::dist_cmd_e cmd_low;
	dn_pkg::dist_cmd_e cmd_high;

	dn_cfg_axil u_cfg (
		.clk              (clk),
		.i_reset          (i_reset),
		.i_s_axil_awvalid (i_s_axil_awvalid),
		.i_s_axil_awaddr  (i_s_axil_awaddr),
		.o_s_axil_awready (o_s_axil_awready),
		.i_s_axil_wvalid  (i_s_axil_wvalid),
		.i_s_axil_wdata   (i_s_axil_wdata),
		.i_s_axil_wstrb   (i_s_axil_wstrb),
		.o_s_axil_wready  (o_s_axil_wready),
		.o_s_axil_bvalid  (o_s_axil_bvalid),
		.o_s_axil_bresp   (o_s_axil_bresp),
		.i_s_axil_bready  (i_s_axil_bready),
		.i_s_axil_arvalid (i_s_axil_arvalid),
		.i_s_axil_araddr  (i_s_axil_araddr),
		.o_s_axil_arready (o_s_axil_arready),
		.o_s_axil_rvalid  (o_s_axil_rvalid),
		.o_s_axil_rdata   (o_s_axil_rdata),
		.o_s_axil_rresp   (o_s_axil_rresp),
		.i_s_axil_rready  (i_s_axil_rready),
		.o_en             (en),
		.o_cmd_root       (cmd_root),
		.o_cmd_low        (cmd_low),
		.o_cmd_high       (cmd_high)
	);

	// two-stage tree, latency 2
	dn_tree_1x4 u_tree (
		.clk        (clk),
		.i_reset    (i_reset),
		.i_en       (en),
		.i_cmd_root (cmd_root),
		.i_cmd_low  (cmd_low),
		.i_cmd_high (cmd_high),
		.i_valid    (i_valid),
		.i_data     (i_data),
		.o_valid    (o_valid),
		.o_data     (o_data)
	);

endmodule

//--- rtl/dn_tree_1x4.sv
module dn_tree_1x4 (
	input  logic                                     clk,
	input  logic                                     i_reset,
	// configuration, sampled with each word at the root
	input  logic                                     i_en,
	input  dn_pkg::dist_cmd_e                        i_cmd_root,
	input  dn_pkg::dist_cmd_e                        i_cmd_low,
	input  dn_pkg::dist_cmd_e                        i_cmd_high,
	// input stream
	input  logic                                     i_valid,
	input  dn_pkg::data_t                            i_data,
	// leaves, leaf 0 in the lowest word
	output logic [dn_pkg::NUM_LEAVES-1:0]            o_valid,
	output dn_pkg::data_t [dn_pkg::NUM_LEAVES-1:0]   o_data
);

	////////////////////
	// level 0, root

	logic [1:0]                     root_valid;
	logic [2*dn_pkg::DATA_WIDTH-1:0] root_data;

	distribute_1x2_simple_comb #(
		.DATA_WIDTH (dn_pkg::DATA_WIDTH)
	) u_root (
		.i_valid    (i_valid),
		.i_data_bus (i_data),
		.i_en       (i_en),
		.i_cmd      (i_cmd_root),
		.o_valid    (root_valid),
		.o_data_bus (root_data)
	);

	////////////////////
	// stage 1 register

	// both branches plus the child settings that belong to this word
	logic [1:0]                      s1_valid;
	logic [2*dn_pkg::DATA_WIDTH-1:0] s1_data;
	logic                            s1_en;
	dn_pkg::dist_cmd_e               s1_cmd_low;
	dn_pkg::dist_cmd_e               s1_cmd_high;

	always_ff @(posedge clk)
	begin
		if (i_reset)
		begin
			s1_valid    <= '0;
			s1_data     <= '0;
			s1_en       <= 1'b0;
			s1_cmd_low  <= dn_pkg::CMD_NONE;
			s1_cmd_high <= dn_pkg::CMD_NONE;
		end
		else
		begin
			s1_valid    <= root_valid;
			s1_data     <= root_data;
			// settings travel with the word, no split across a reconfig
			s1_en       <= i_en;
			s1_cmd_low  <= i_cmd_low;
			s1_cmd_high <= i_cmd_high;
		end
	end

	////////////////////
	// level 1, children

	logic [1:0]                      low_valid;
	logic [2*dn_pkg::DATA_WIDTH-1:0] low_data;
	logic [1:0]                      high_valid;
	logic [2*dn_pkg::DATA_WIDTH-1:0] high_data;

	// low child feeds leaves 0 and 1
	distribute_1x2_simple_comb #(
		.DATA_WIDTH (dn_pkg::DATA_WIDTH)
	) u_child_low (
		.i_valid    (s1_valid[0]),
		.i_data_bus (s1_data[0 +: dn_pkg::DATA_WIDTH]),
		.i_en       (s1_en),
		.i_cmd      (s1_cmd_low),
		.o_valid    (low_valid),
		.o_data_bus (low_data)
	);

	// high child feeds leaves 2 and 3
	distribute_1x2_simple_comb #(
		.DATA_WIDTH (dn_pkg::DATA_WIDTH)
	) u_child_high (
		.i_valid    (s1_valid[1]),
		.i_data_bus (s1_data[dn_pkg::DATA_WIDTH +: dn_pkg::DATA_WIDTH]),
		.i_en       (s1_en),
		.i_cmd      (s1_cmd_high),
		.o_valid    (high_valid),
		.o_data_bus (high_data)
	);

	////////////////////
	// output register

	always_ff @(posedge clk)
	begin
		if (i_reset)
		begin
			o_valid <= '0;
			o_data  <= '0;
		end
		else
		begin
			// leaf order 3..0
			o_valid <= {high_valid, low_valid};
			o_data  <= {high_data, low_data};
		end
	end

endmodule

//--- rtl/mux_2x1_simple_comb.sv
module mux_2x1_simple_comb #(
	parameter int DATA_WIDTH = 32
)(
	// two valid/data pairs, pair 1 in the upper word
	input  logic [1:0]              i_valid,
	input  logic [2*DATA_WIDTH-1:0] i_data_bus,
	// control
	input  logic                    i_en,
	input  logic                    i_cmd,
	// selected pair
	output logic                    o_valid,
	output logic [DATA_WIDTH-1:0]   o_data_bus
);

	logic                  sel_valid;
	logic [DATA_WIDTH-1:0] sel_data;

	always_comb
	begin
		// pick the pair named by the select bit
		sel_valid = i_valid[i_cmd];
		sel_data  = i_data_bus[i_cmd*DATA_WIDTH +: DATA_WIDTH];

		// disabled or empty pair gives zero dummy data
		if (i_en && sel_valid)
		begin
			o_valid    = 1'b1;
			o_data_bus = sel_data;
		end
		else
		begin
			o_valid    = 1'b0;
			o_data_bus = '0;
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and decide from the log
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module dn_tb -f dist_net.f -o dn_sim \
	|| { echo "verilator build failed"; exit 1; }
./obj_dir/dn_sim > sim.log 2>&1
cat sim.log
grep -q "All tests passed!" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- sim/dn_tb.sv
module dn_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT_CYCLES = 50;
	localparam int NUM_ROWS       = 66;

	logic                                   clk;
	logic                                   i_reset;
	logic                                   awvalid;
	logic [dn_pkg::AXIL_ADDR_WIDTH-1:0]     awaddr;
	logic                                   awready;
	logic                                   wvalid;
	logic [dn_pkg::AXIL_DATA_WIDTH-1:0]     wdata;
	logic [dn_pkg::AXIL_DATA_WIDTH/8-1:0]   wstrb;
	logic                                   wready;
	logic                                   bvalid;
	dn_pkg::axil_resp_e                     bresp;
	logic                                   bready;
	logic                                   arvalid;
	logic [dn_pkg::AXIL_ADDR_WIDTH-1:0]     araddr;
	logic                                   arready;
	logic                                   rvalid;
	logic [dn_pkg::AXIL_DATA_WIDTH-1:0]     rdata;
	dn_pkg::axil_resp_e                     rresp;
	logic                                   rready;
	logic                                   in_valid;
	dn_pkg::data_t                          in_data;
	logic [dn_pkg::NUM_LEAVES-1:0]          out_valid;
	dn_pkg::data_t [dn_pkg::NUM_LEAVES-1:0] out_data;

	// one routing case: settings plus the word sent through
	typedef struct {
		logic              en;
		dn_pkg::dist_cmd_e cmd_root;
		dn_pkg::dist_cmd_e cmd_low;
		dn_pkg::dist_cmd_e cmd_high;
		dn_pkg::data_t     data;
	} row_t;

	row_t        stim_rows [NUM_ROWS];
	logic [31:0] rng_state = 32'd52129;

	dn_top u_dn_top (
		.clk              (clk),
		.i_reset          (i_reset),
		.i_s_axil_awvalid (awvalid),
		.i_s_axil_awaddr  (awaddr),
		.o_s_axil_awready (awready),
		.i_s_axil_wvalid  (wvalid),
		.i_s_axil_wdata   (wdata),
		.i_s_axil_wstrb   (wstrb),
		.o_s_axil_wready  (wready),
		.o_s_axil_bvalid  (bvalid),
		.o_s_axil_bresp   (bresp),
		.i_s_axil_bready  (bready),
		.i_s_axil_arvalid (arvalid),
		.i_s_axil_araddr  (araddr),
		.o_s_axil_arready (arready),
		.o_s_axil_rvalid  (rvalid),
		.o_s_axil_rdata   (rdata),
		.o_s_axil_rresp   (rresp),
		.i_s_axil_rready  (rready),
		.i_valid          (in_valid),
		.i_data           (in_data),
		.o_valid          (out_valid),
		.o_data           (out_data)
	);

	// 20 ns period
	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////
	// helpers

	task automatic report_failure();
		$display("Test failures found");
		$fatal(1);
	endtask

	// xorshift32 for the data words
	function automatic dn_pkg::data_t next_word();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// routing rule, leaf valid needs every switch on its path to select it
	function automatic void predict_leaves(
		input  logic                                   en,
		input  dn_pkg::dist_cmd_e                      cmd_root,
		input  dn_pkg::dist_cmd_e                      cmd_low,
		input  dn_pkg::dist_cmd_e                      cmd_high,
		input  logic                                   valid,
		input  dn_pkg::data_t                          data,
		output logic [dn_pkg::NUM_LEAVES-1:0]          mask,
		output dn_pkg::data_t [dn_pkg::NUM_LEAVES-1:0] words
	);
		logic root_sel;
		logic child_sel;
		int   leaf;
		for (leaf = 0; leaf < dn_pkg::NUM_LEAVES; leaf++)
		begin
			// leaves 2 and 3 sit under the root's high branch
			root_sel = (leaf >= 2) ? cmd_root[1] : cmd_root[0];
			// odd leaf is the child's high branch
			if (leaf >= 2)
				child_sel = (leaf % 2 == 1) ? cmd_high[1] : cmd_high[0];
			else
				child_sel = (leaf % 2 == 1) ? cmd_low[1] : cmd_low[0];
			mask[leaf]  = valid && en && root_sel && child_sel;
			words[leaf] = mask[leaf] ? data : '0;
		end
	endfunction

	////////////////////
	// compare tasks

	task automatic check_mask(input string name, input logic [dn_pkg::NUM_LEAVES-1:0] expected,
		input logic [dn_pkg::NUM_LEAVES-1:0] actual);
		if (expected !== actual)
		begin
			$display("FAILED %s expected 0x%h actual 0x%h", name, expected, actual);
			report_failure();
		end
	endtask

	task automatic check_data(input string name, input dn_pkg::data_t expected,
		input dn_pkg::data_t actual);
		if (expected !== actual)
		begin
			$display("FAILED %s expected 0x%h actual 0x%h", name, expected, actual);
			report_failure();
		end
	endtask

	task automatic check_resp(input string name, input dn_pkg::axil_resp_e expected,
		input dn_pkg::axil_resp_e actual);
		if (expected !== actual)
		begin
			$display("FAILED %s expected 0x%h actual 0x%h", name, expected, actual);
			report_failure();
		end
	endtask

	task automatic check_reg(input string name, input logic [dn_pkg::AXIL_DATA_WIDTH-1:0] expected,
		input logic [dn_pkg::AXIL_DATA_WIDTH-1:0] actual);
		if (expected !== actual)
		begin
			$display("FAILED %s expected 0x%h actual 0x%h", name, expected, actual);
			report_failure();
		end
	endtask

	// all leaves, sampled at the falling edge
	task automatic check_outputs(input logic [dn_pkg::NUM_LEAVES-1:0] mask,
		input dn_pkg::data_t [dn_pkg::NUM_LEAVES-1:0] words);
		int leaf;
		check_mask("o_valid", mask, out_valid);
		for (leaf = 0; leaf < dn_pkg::NUM_LEAVES; leaf++)
			check_data($sformatf("o_data[%0d]", leaf), words[leaf], out_data[leaf]);
	endtask

	////////////////////
	// AXI4-Lite master

	// hold_cycles keeps bready low that many cycles after bvalid rises
	task automatic axi_write(input logic [dn_pkg::AXIL_ADDR_WIDTH-1:0] addr,
		input logic [dn_pkg::AXIL_DATA_WIDTH-1:0] data,
		input logic [dn_pkg::AXIL_DATA_WIDTH/8-1:0] strb,
		input int hold_cycles, output dn_pkg::axil_resp_e resp);
		int cycles;
		int i;
		@(posedge clk);
		awvalid <= 1'b1;
		awaddr  <= addr;
		wvalid  <= 1'b1;
		wdata   <= data;
		wstrb   <= strb;
		cycles = 0;
		@(negedge clk);
		while (!(awready && wready))
		begin
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
			begin
				$display("timeout waiting for the write address and data to be accepted");
				report_failure();
			end
			@(negedge clk);
		end
		// handshake edge
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		bready  <= (hold_cycles == 0);
		cycles = 0;
		@(negedge clk);
		while (!bvalid)
		begin
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
			begin
				$display("timeout waiting for the write response");
				report_failure();
			end
			@(negedge clk);
		end
		resp = bresp;
		// response must stay up while bready is low
		for (i = 0; i < hold_cycles; i++)
		begin
			@(negedge clk);
			if (!bvalid)
			begin
				$display("write response dropped while bready was still low");
				report_failure();
			end
		end
		if (hold_cycles > 0)
		begin
			@(posedge clk);
			bready <= 1'b1;
		end
		@(posedge clk);
		bready <= 1'b0;
		cycles = 0;
		@(negedge clk);
		while (bvalid)
		begin
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
			begin
				$display("timeout waiting for the write response to retire");
				report_failure();
			end
			@(negedge clk);
		end
	endtask

	task automatic axi_read(input logic [dn_pkg::AXIL_ADDR_WIDTH-1:0] addr,
		output logic [dn_pkg::AXIL_DATA_WIDTH-1:0] data, output dn_pkg::axil_resp_e resp);
		int cycles;
		@(posedge clk);
		arvalid <= 1'b1;
		araddr  <= addr;
		cycles = 0;
		@(negedge clk);
		while (!arready)
		begin
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
			begin
				$display("timeout waiting for the read address to be accepted");
				report_failure();
			end
			@(negedge clk);
		end
		@(posedge clk);
		arvalid <= 1'b0;
		rready  <= 1'b1;
		cycles = 0;
		@(negedge clk);
		while (!rvalid)
		begin
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
			begin
				$display("timeout waiting for the read data");
				report_failure();
			end
			@(negedge clk);
		end
		data = rdata;
		resp = rresp;
		// rvalid drops on this edge
		@(posedge clk);
		rready <= 1'b0;
	endtask

	// configure both registers and read the command word back
	task automatic load_config(input logic en, input dn_pkg::dist_cmd_e cmd_root,
		input dn_pkg::dist_cmd_e cmd_low, input dn_pkg::dist_cmd_e cmd_high);
		dn_pkg::axil_resp_e                 resp;
		logic [dn_pkg::AXIL_DATA_WIDTH-1:0] cmd_word;
		logic [dn_pkg::AXIL_DATA_WIDTH-1:0] rd;
		cmd_word = {26'd0, cmd_high, cmd_low, cmd_root};
		axi_write(dn_pkg::REG_CTRL_ADDR, {31'd0, en}, 4'hf, 0, resp);
		check_resp("bresp", dn_pkg::RESP_OKAY, resp);
		axi_write(dn_pkg::REG_CMD_ADDR, cmd_word, 4'hf, 0, resp);
		check_resp("bresp", dn_pkg::RESP_OKAY, resp);
		axi_read(dn_pkg::REG_CMD_ADDR, rd, resp);
		check_resp("rresp", dn_pkg::RESP_OKAY, resp);
		check_reg("cmd register", cmd_word, rd);
	endtask

	// one-cycle valid pulse, returns one edge after the drive edge
	task automatic send_word(input dn_pkg::data_t data);
		@(posedge clk);
		in_valid <= 1'b1;
		in_data  <= data;
		@(posedge clk);
		in_valid <= 1'b0;
		in_data  <= '0;
	endtask

	////////////////////
	// test sequence

	initial
	begin
		dn_pkg::axil_resp_e                     resp;
		logic [dn_pkg::AXIL_DATA_WIDTH-1:0]     rd;
		logic [dn_pkg::NUM_LEAVES-1:0]          mask;
		logic [dn_pkg::NUM_LEAVES-1:0]          mask_b;
		dn_pkg::data_t [dn_pkg::NUM_LEAVES-1:0] words;
		dn_pkg::data_t [dn_pkg::NUM_LEAVES-1:0] words_b;
		dn_pkg::data_t                          word_a;
		dn_pkg::data_t                          word_b;
		int                                     r;

		i_reset  <= 1'b1;
		awvalid  <= 1'b0;
		awaddr   <= '0;
		wvalid   <= 1'b0;
		wdata    <= '0;
		wstrb    <= '0;
		bready   <= 1'b0;
		arvalid  <= 1'b0;
		araddr   <= '0;
		rready   <= 1'b0;
		in_valid <= 1'b0;
		in_data  <= '0;

		// every root/low/high combination, then two rows with enable off
		for (r = 0; r < 64; r++)
		begin
			stim_rows[r].en       = 1'b1;
			stim_rows[r].cmd_root = dn_pkg::dist_cmd_e'(r[5:4]);
			stim_rows[r].cmd_low  = dn_pkg::dist_cmd_e'(r[3:2]);
			stim_rows[r].cmd_high = dn_pkg::dist_cmd_e'(r[1:0]);
			stim_rows[r].data     = next_word();
		end
		stim_rows[64] = '{1'b0, dn_pkg::CMD_DUP, dn_pkg::CMD_DUP, dn_pkg::CMD_DUP, next_word()};
		stim_rows[65] = '{1'b0, dn_pkg::CMD_LOW, dn_pkg::CMD_LOW, dn_pkg::CMD_HIGH, next_word()};

		// reset for two edges
		repeat (2) @(posedge clk);
		i_reset <= 1'b0;

		// reset state
		@(negedge clk);
		check_outputs('0, '0);
		axi_read(dn_pkg::REG_CTRL_ADDR, rd, resp);
		check_resp("rresp", dn_pkg::RESP_OKAY, resp);
		check_reg("ctrl register", '0, rd);
		axi_read(dn_pkg::REG_CMD_ADDR, rd, resp);
		check_resp("rresp", dn_pkg::RESP_OKAY, resp);
		check_reg("cmd register", '0, rd);

		// routing table, leaves update two edges after the drive edge
		for (r = 0; r < NUM_ROWS; r++)
		begin
			load_config(stim_rows[r].en, stim_rows[r].cmd_root,
				stim_rows[r].cmd_low, stim_rows[r].cmd_high);
			predict_leaves(stim_rows[r].en, stim_rows[r].cmd_root, stim_rows[r].cmd_low,
				stim_rows[r].cmd_high, 1'b1, stim_rows[r].data, mask, words);
			send_word(stim_rows[r].data);
			@(posedge clk);
			@(negedge clk);
			check_outputs(mask, words);
		end

		// back-to-back words, leaves 2 and 3
		load_config(1'b1, dn_pkg::CMD_HIGH, dn_pkg::CMD_LOW, dn_pkg::CMD_DUP);
		word_a = next_word();
		word_b = next_word();
		predict_leaves(1'b1, dn_pkg::CMD_HIGH, dn_pkg::CMD_LOW, dn_pkg::CMD_DUP,
			1'b1, word_a, mask, words);
		predict_leaves(1'b1, dn_pkg::CMD_HIGH, dn_pkg::CMD_LOW, dn_pkg::CMD_DUP,
			1'b1, word_b, mask_b, words_b);
		@(posedge clk);
		in_valid <= 1'b1;
		in_data  <= word_a;
		@(posedge clk);
		in_data  <= word_b;
		// nothing out yet
		@(negedge clk);
		check_outputs('0, '0);
		@(posedge clk);
		in_valid <= 1'b0;
		in_data  <= '0;
		@(negedge clk);
		check_outputs(mask, words);
		@(posedge clk);
		@(negedge clk);
		check_outputs(mask_b, words_b);
		// pipe drained
		@(posedge clk);
		@(negedge clk);
		check_outputs('0, '0);

		// byte strobes on the command register
		axi_write(dn_pkg::REG_CMD_ADDR, 32'h0000_003f, 4'hf, 0, resp);
		check_resp("bresp", dn_pkg::RESP_OKAY, resp);
		axi_write(dn_pkg::REG_CMD_ADDR, 32'hffff_ff00, 4'b1110, 0, resp);
		check_resp("bresp", dn_pkg::RESP_OKAY, resp);
		axi_read(dn_pkg::REG_CMD_ADDR, rd, resp);
		check_reg("cmd register", 32'h0000_003f, rd);
		axi_write(dn_pkg::REG_CMD_ADDR, 32'hffff_ff12, 4'b0001, 0, resp);
		axi_read(dn_pkg::REG_CMD_ADDR, rd, resp);
		check_reg("cmd register", 32'h0000_0012, rd);
		// enable is still set, upper strobes leave it alone
		axi_write(dn_pkg::REG_CTRL_ADDR, 32'h0000_0000, 4'b1110, 0, resp);
		axi_read(dn_pkg::REG_CTRL_ADDR, rd, resp);
		check_reg("ctrl register", 32'h0000_0001, rd);
		axi_write(dn_pkg::REG_CTRL_ADDR, 32'h0000_0000, 4'b0001, 0, resp);
		axi_read(dn_pkg::REG_CTRL_ADDR, rd, resp);
		check_reg("ctrl register", 32'h0000_0000, rd);

		// unmapped addresses
		axi_write(4'h8, 32'hffff_ffff, 4'hf, 0, resp);
		check_resp("bresp", dn_pkg::RESP_SLVERR, resp);
		axi_read(4'hc, rd, resp);
		check_resp("rresp", dn_pkg::RESP_SLVERR, resp);
		axi_read(dn_pkg::REG_CTRL_ADDR, rd, resp);
		check_reg("ctrl register", 32'h0000_0000, rd);
		axi_read(dn_pkg::REG_CMD_ADDR, rd, resp);
		check_reg("cmd register", 32'h0000_0012, rd);

		// bready held low for a while
		axi_write(dn_pkg::REG_CTRL_ADDR, 32'h0000_0001, 4'hf, 5, resp);
		check_resp("bresp", dn_pkg::RESP_OKAY, resp);
		axi_read(dn_pkg::REG_CTRL_ADDR, rd, resp);
		check_reg("ctrl register", 32'h0000_0001, rd);

		$display("All tests passed!");
		$finish;
	end

endmodule
